//--- include/padframe_cfg.svh
/*
 * padframe configuration sizes
 * pad count, register map and crossing parameters
 */

`ifndef PADFRAME_CFG_SVH
`define PADFRAME_CFG_SVH

// muxed pads and their fields
`define PAD_NUM_PADS      16
`define PAD_FIELD_W       4
`define PAD_PADS_PER_WORD 8
`define PAD_REG_COUNT     2

// register bus
`define PAD_ADDR_W        4
`define PAD_DATA_W        32

// host queue and crossing
`define PAD_FIFO_DEPTH    4
`define PAD_SYNC_STAGES   2

`endif

//--- logic/pad_mux.sv
/*
 * muxed pad routing
 * each pad carries gpio, alternate A, alternate B or nothing per its field
 */

`timescale 1ns/1ps

`include "padframe_cfg.svh"

module pad_mux (
  input  padframe_pkg::pad_cfg_word_u cfg_i [`PAD_REG_COUNT],
  input  logic [`PAD_NUM_PADS-1:0]    gpio_out_i,
  input  logic [`PAD_NUM_PADS-1:0]    gpio_oe_i,
  input  logic [`PAD_NUM_PADS-1:0]    alt_a_out_i,
  input  logic [`PAD_NUM_PADS-1:0]    alt_b_out_i,
  input  logic [`PAD_NUM_PADS-1:0]    pad_in_i,
  output logic [`PAD_NUM_PADS-1:0]    pad_out_o,
  output logic [`PAD_NUM_PADS-1:0]    pad_oe_o,
  output logic [`PAD_NUM_PADS-1:0]    gpio_in_o,
  output logic [`PAD_NUM_PADS-1:0]    alt_in_o
);

  always_comb begin
    padframe_pkg::pad_field_t fld;
    fld       = '0;
    pad_out_o = '0;
    pad_oe_o  = '0;
    gpio_in_o = '0;
    alt_in_o  = '0;
    for (int n = 0; n < `PAD_NUM_PADS; n++) begin
      fld = cfg_i[n / `PAD_PADS_PER_WORD].field[n % `PAD_PADS_PER_WORD];
      case (fld.sel)
        padframe_pkg::PAD_SEL_GPIO: begin
          pad_out_o[n] = gpio_out_i[n];
          pad_oe_o[n]  = gpio_oe_i[n];
          gpio_in_o[n] = pad_in_i[n];
        end
        // alternates take the enable from the field
        padframe_pkg::PAD_SEL_ALT_A: begin
          pad_out_o[n] = alt_a_out_i[n];
          pad_oe_o[n]  = fld.oe;
          alt_in_o[n]  = pad_in_i[n];
        end
        padframe_pkg::PAD_SEL_ALT_B: begin
          pad_out_o[n] = alt_b_out_i[n];
          pad_oe_o[n]  = fld.oe;
          alt_in_o[n]  = pad_in_i[n];
        end
        default: ;
      endcase
    end
  end

endmodule

//--- logic/padframe_cfg_regs.sv
/*
 * padframe configuration registers
 * two words of per-pad fields with bus read/write decode
 */

`timescale 1ns/1ps

`include "padframe_cfg.svh"

module padframe_cfg_regs (
  input  logic                        ref_clk_i,
  input  logic                        rst_n_i,
  reg_bus_if.slave                    bus,
  output padframe_pkg::pad_cfg_word_u cfg_o [`PAD_REG_COUNT]
);

  localparam int IDX_W = $clog2(`PAD_REG_COUNT);

  // every pad off, output disabled
  localparam padframe_pkg::pad_field_t RST_FIELD = '{
    rsvd: 1'b0,
    oe:   1'b0,
    sel:  padframe_pkg::PAD_SEL_OFF
  };
  localparam logic [`PAD_PADS_PER_WORD*`PAD_FIELD_W-1:0] RST_WORD =
    {`PAD_PADS_PER_WORD{RST_FIELD}};

  padframe_pkg::pad_cfg_word_u cfg_q [`PAD_REG_COUNT];
  padframe_pkg::pad_cfg_word_u wr_word;
  logic                        addr_ok;
  logic [IDX_W-1:0]            idx;

  assign addr_ok = (bus.addr < `PAD_ADDR_W'(`PAD_REG_COUNT));
  assign idx     = bus.addr[IDX_W-1:0];

  // reserved bits never stored
  always_comb begin
    wr_word.raw = bus.wdata;
    for (int f = 0; f < `PAD_PADS_PER_WORD; f++) begin
      wr_word.field[f].rsvd = 1'b0;
    end
  end

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int w = 0; w < `PAD_REG_COUNT; w++) begin
        cfg_q[w].raw <= RST_WORD;
      end
    end else if (bus.valid && bus.write && addr_ok) begin
      cfg_q[idx] <= wr_word;
    end
  end

  // writes read back zero, bad addresses flag error
  assign bus.rdata = (!bus.write && addr_ok) ? cfg_q[idx].raw : '0;
  assign bus.error = ~addr_ok;

  assign cfg_o = cfg_q;

endmodule

//--- logic/padframe_pkg.sv
/*
 * padframe types
 * pad selection, per-pad field, configuration word and register request/response
 */

`include "padframe_cfg.svh"

package padframe_pkg;

  typedef enum logic [1:0] {
    PAD_SEL_GPIO  = 2'd0,
    PAD_SEL_ALT_A = 2'd1,
    PAD_SEL_ALT_B = 2'd2,
    PAD_SEL_OFF   = 2'd3
  } pad_sel_e;

  // one nibble per pad, msb is reserved
  typedef struct packed {
    logic     rsvd;
    logic     oe;
    pad_sel_e sel;
  } pad_field_t;

  // raw view for the bus, field view for pad routing
  typedef union packed {
    logic [`PAD_DATA_W-1:0]                    raw;
    pad_field_t [`PAD_PADS_PER_WORD-1:0]       field;
  } pad_cfg_word_u;

  typedef struct packed {
    logic                   write;
    logic [`PAD_ADDR_W-1:0] addr;
    logic [`PAD_DATA_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [`PAD_DATA_W-1:0] rdata;
    logic                   error;
  } reg_rsp_t;

endpackage

//--- logic/padframe_top.sv
/*
 * padframe configuration path
 * host request queue, four-phase crossing to ref_clk, config registers and pad mux
 */

`timescale 1ns/1ps

`include "padframe_cfg.svh"

module padframe_top (
  input  logic                     host_clk_i,
  input  logic                     ref_clk_i,
  input  logic                     rst_n_i,
  // host request port
  input  logic                     req_valid_i,
  input  logic                     req_write_i,
  input  logic [`PAD_ADDR_W-1:0]   req_addr_i,
  input  logic [`PAD_DATA_W-1:0]   req_wdata_i,
  output logic                     req_full_o,
  output logic                     rsp_valid_o,
  output logic [`PAD_DATA_W-1:0]   rsp_rdata_o,
  output logic                     rsp_error_o,
  // pads
  input  logic [`PAD_NUM_PADS-1:0] gpio_out_i,
  input  logic [`PAD_NUM_PADS-1:0] gpio_oe_i,
  input  logic [`PAD_NUM_PADS-1:0] alt_a_out_i,
  input  logic [`PAD_NUM_PADS-1:0] alt_b_out_i,
  input  logic [`PAD_NUM_PADS-1:0] pad_in_i,
  output logic [`PAD_NUM_PADS-1:0] pad_out_o,
  output logic [`PAD_NUM_PADS-1:0] pad_oe_o,
  output logic [`PAD_NUM_PADS-1:0] gpio_in_o,
  output logic [`PAD_NUM_PADS-1:0] alt_in_o
);

  padframe_pkg::reg_req_t      push_data;
  padframe_pkg::reg_req_t      pop_data;
  padframe_pkg::reg_rsp_t      rsp;
  padframe_pkg::pad_cfg_word_u cfg_words [`PAD_REG_COUNT];
  logic                        fifo_empty;
  logic                        fifo_pop;

  reg_async_if async_if ();
  reg_bus_if   bus_if ();

  assign push_data.write = req_write_i;
  assign push_data.addr  = req_addr_i;
  assign push_data.wdata = req_wdata_i;

  assign rsp_rdata_o = rsp.rdata;
  assign rsp_error_o = rsp.error;

  //////////////////////////////////////////////////////////////////////
  // host domain
  //////////////////////////////////////////////////////////////////////

  reg_req_fifo i_req_fifo (
    .host_clk_i  ( host_clk_i  ),
    .rst_n_i     ( rst_n_i     ),
    .push_i      ( req_valid_i ),
    .push_data_i ( push_data   ),
    .full_o      ( req_full_o  ),
    .empty_o     ( fifo_empty  ),
    .pop_i       ( fifo_pop    ),
    .pop_data_o  ( pop_data    )
  );

  reg_cdc_src i_cdc_src (
    .host_clk_i  ( host_clk_i  ),
    .rst_n_i     ( rst_n_i     ),
    .empty_i     ( fifo_empty  ),
    .pop_o       ( fifo_pop    ),
    .pop_data_i  ( pop_data    ),
    .async       ( async_if    ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp         )
  );

  //////////////////////////////////////////////////////////////////////
  // reference domain
  //////////////////////////////////////////////////////////////////////

  reg_cdc_dst i_cdc_dst (
    .ref_clk_i ( ref_clk_i ),
    .rst_n_i   ( rst_n_i   ),
    .async     ( async_if  ),
    .bus       ( bus_if    )
  );

  padframe_cfg_regs i_cfg_regs (
    .ref_clk_i ( ref_clk_i ),
    .rst_n_i   ( rst_n_i   ),
    .bus       ( bus_if    ),
    .cfg_o     ( cfg_words )
  );

  pad_mux i_pad_mux (
    .cfg_i       ( cfg_words   ),
    .gpio_out_i  ( gpio_out_i  ),
    .gpio_oe_i   ( gpio_oe_i   ),
    .alt_a_out_i ( alt_a_out_i ),
    .alt_b_out_i ( alt_b_out_i ),
    .pad_in_i    ( pad_in_i    ),
    .pad_out_o   ( pad_out_o   ),
    .pad_oe_o    ( pad_oe_o    ),
    .gpio_in_o   ( gpio_in_o   ),
    .alt_in_o    ( alt_in_o    )
  );

endmodule

//--- logic/reg_async_if.sv
/*
 * four-phase request/acknowledge channel
 * carries one register request and its response between clock domains
 */

`timescale 1ns/1ps

interface reg_async_if;

  // source side
  logic                   req;
  padframe_pkg::reg_req_t req_data;

  // destination side
  logic                   ack;
  padframe_pkg::reg_rsp_t rsp_data;

  modport src (
    output req,
    output req_data,
    input  ack,
    input  rsp_data
  );

  modport dst (
    input  req,
    input  req_data,
    output ack,
    output rsp_data
  );

endinterface

//--- logic/reg_bus_if.sv
/*
 * reference-domain register bus
 * single-cycle access, response returned in the same cycle
 */

`timescale 1ns/1ps

`include "padframe_cfg.svh"

interface reg_bus_if;

  logic                   valid;
  logic                   write;
  logic [`PAD_ADDR_W-1:0] addr;
  logic [`PAD_DATA_W-1:0] wdata;
  logic [`PAD_DATA_W-1:0] rdata;
  logic                   error;

  modport master (output valid, output write, output addr, output wdata,
                  input rdata, input error);

  modport slave (input valid, input write, input addr, input wdata,
                 output rdata, output error);

endinterface

//--- logic/reg_cdc_dst.sv
/*
 * four-phase crossing destination
 * turns each synchronized request into one register bus access in ref_clk
 */

`timescale 1ns/1ps

`include "padframe_cfg.svh"

module reg_cdc_dst (
  input  logic      ref_clk_i,
  input  logic      rst_n_i,
  reg_async_if.dst  async,
  reg_bus_if.master bus
);

  logic [`PAD_SYNC_STAGES-1:0] req_sync_q;
  logic                        req_seen;
  logic                        req_rise;
  logic                        ack_q;
  padframe_pkg::reg_rsp_t      rsp_q;

  //////////////////////////////////////////////////////////////////////
  // req synchronizer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_sync_q <= '0;
    end else begin
      req_sync_q <= {req_sync_q[`PAD_SYNC_STAGES-2:0], async.req};
    end
  end

  assign req_seen = req_sync_q[`PAD_SYNC_STAGES-1];

  // new request until ack has been raised for it
  assign req_rise = req_seen & ~ack_q;

  //////////////////////////////////////////////////////////////////////
  // bus access and ack
  //////////////////////////////////////////////////////////////////////

  // req_data is stable while req is high
  assign bus.valid = req_rise;
  assign bus.write = async.req_data.write;
  assign bus.addr  = async.req_data.addr;
  assign bus.wdata = async.req_data.wdata;

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else if (req_rise) begin
      ack_q <= 1'b1;
    end else if (!req_seen) begin
      ack_q <= 1'b0;
    end
  end

  always_ff @(posedge ref_clk_i) begin
    if (req_rise) begin
      rsp_q.rdata <= bus.rdata;
      rsp_q.error <= bus.error;
    end
  end

  assign async.ack      = ack_q;
  assign async.rsp_data = rsp_q;

endmodule

//--- logic/reg_cdc_src.sv
/*
 * four-phase crossing source
 * drives queued requests onto the channel and returns responses to the host
 */

`timescale 1ns/1ps

`include "padframe_cfg.svh"

module reg_cdc_src (
  input  logic                   host_clk_i,
  input  logic                   rst_n_i,
  input  logic                   empty_i,
  output logic                   pop_o,
  input  padframe_pkg::reg_req_t pop_data_i,
  reg_async_if.src               async,
  output logic                   rsp_valid_o,
  output padframe_pkg::reg_rsp_t rsp_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACK_HI,
    ST_ACK_LO
  } state_e;

  state_e                       state_q;
  logic                         req_q;
  logic                         rsp_valid_q;
  logic [`PAD_SYNC_STAGES-1:0]  ack_sync_q;
  logic                         ack_seen;
  padframe_pkg::reg_req_t       req_data_q;
  padframe_pkg::reg_rsp_t       rsp_q;

  //////////////////////////////////////////////////////////////////////
  // ack synchronizer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge host_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_sync_q <= '0;
    end else begin
      ack_sync_q <= {ack_sync_q[`PAD_SYNC_STAGES-2:0], async.ack};
    end
  end

  assign ack_seen = ack_sync_q[`PAD_SYNC_STAGES-1];

  //////////////////////////////////////////////////////////////////////
  // handshake FSM
  //////////////////////////////////////////////////////////////////////

  assign pop_o = (state_q == ST_IDLE) & ~empty_i;

  always_ff @(posedge host_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      req_q       <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (!empty_i) begin
            req_q   <= 1'b1;
            state_q <= ST_ACK_HI;
          end
        end
        ST_ACK_HI: begin
          // response is valid once ack is seen
          if (ack_seen) begin
            req_q       <= 1'b0;
            rsp_valid_q <= 1'b1;
            state_q     <= ST_ACK_LO;
          end
        end
        ST_ACK_LO: begin
          if (!ack_seen) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge host_clk_i) begin
    if (pop_o) begin
      req_data_q <= pop_data_i;
    end
    if (state_q == ST_ACK_HI && ack_seen) begin
      rsp_q <= async.rsp_data;
    end
  end

  assign async.req      = req_q;
  assign async.req_data = req_data_q;
  assign rsp_valid_o    = rsp_valid_q;
  assign rsp_o          = rsp_q;

endmodule

//--- logic/reg_req_fifo.sv
/*
 * host-domain request queue
 * circular buffer so the host can issue several register accesses back to back
 */

`timescale 1ns/1ps

`include "padframe_cfg.svh"

module reg_req_fifo (
  input  logic                   host_clk_i,
  input  logic                   rst_n_i,
  input  logic                   push_i,
  input  padframe_pkg::reg_req_t push_data_i,
  output logic                   full_o,
  output logic                   empty_o,
  input  logic                   pop_i,
  output padframe_pkg::reg_req_t pop_data_o
);

  localparam int PTR_W = $clog2(`PAD_FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  padframe_pkg::reg_req_t mem_q [`PAD_FIFO_DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       count_q;
  logic                   push_en;
  logic                   pop_en;

  // pushes while full are dropped
  assign push_en = push_i & ~full_o;
  assign pop_en  = pop_i & ~empty_o;

  assign full_o     = (count_q == CNT_W'(`PAD_FIFO_DEPTH));
  assign empty_o    = (count_q == '0);
  assign pop_data_o = mem_q[rd_ptr_q];

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge host_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge host_clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

//--- project.f
+incdir+include
logic/padframe_pkg.sv
logic/reg_async_if.sv
logic/reg_bus_if.sv
logic/reg_req_fifo.sv
logic/reg_cdc_src.sv
logic/reg_cdc_dst.sv
logic/padframe_cfg_regs.sv
logic/pad_mux.sv
logic/padframe_top.sv
test/padframe_tb.sv

//--- test/padframe_tb.sv
/*
 * padframe testbench
 * random register traffic across the crossing, checked against a model
 * of the configuration words and of the pad routing
 */

`timescale 1ns/1ps

`include "padframe_cfg.svh"

module padframe_tb;

  localparam int P2_OPS        = 40;
  localparam int P3_OPS        = 16;
  localparam int BURSTS        = 3;
  localparam int BURST_LEN     = 12;
  localparam int NUM_OPS       = 4 + P2_OPS + P3_OPS + BURSTS * BURST_LEN;
  localparam int REF_PERIOD_NS = 56;

  // reserved bit of every nibble reads zero
  localparam logic [`PAD_DATA_W-1:0] RSVD_CLR = 32'h7777_7777;

  typedef struct packed {
    logic [`PAD_DATA_W-1:0] rdata;
    logic                   error;
    logic                   pads;
    logic [`PAD_DATA_W-1:0] w0;
    logic [`PAD_DATA_W-1:0] w1;
  } exp_t;

  logic                     host_clk;
  logic                     ref_clk;
  logic                     rst_n;
  logic                     req_valid;
  logic                     req_write;
  logic [`PAD_ADDR_W-1:0]   req_addr;
  logic [`PAD_DATA_W-1:0]   req_wdata;
  logic                     req_full;
  logic                     rsp_valid;
  logic [`PAD_DATA_W-1:0]   rsp_rdata;
  logic                     rsp_error;
  logic [`PAD_NUM_PADS-1:0] gpio_out;
  logic [`PAD_NUM_PADS-1:0] gpio_oe;
  logic [`PAD_NUM_PADS-1:0] alt_a_out;
  logic [`PAD_NUM_PADS-1:0] alt_b_out;
  logic [`PAD_NUM_PADS-1:0] pad_in;
  logic [`PAD_NUM_PADS-1:0] pad_out;
  logic [`PAD_NUM_PADS-1:0] pad_oe;
  logic [`PAD_NUM_PADS-1:0] gpio_in;
  logic [`PAD_NUM_PADS-1:0] alt_in;

  logic [`PAD_DATA_W-1:0] model_words [`PAD_REG_COUNT];
  exp_t                   exp_q [$];
  string                  name_q [$];
  logic                   saw_full;

  padframe_top padframe_top_i (
    .host_clk_i  ( host_clk  ),
    .ref_clk_i   ( ref_clk   ),
    .rst_n_i     ( rst_n     ),
    .req_valid_i ( req_valid ),
    .req_write_i ( req_write ),
    .req_addr_i  ( req_addr  ),
    .req_wdata_i ( req_wdata ),
    .req_full_o  ( req_full  ),
    .rsp_valid_o ( rsp_valid ),
    .rsp_rdata_o ( rsp_rdata ),
    .rsp_error_o ( rsp_error ),
    .gpio_out_i  ( gpio_out  ),
    .gpio_oe_i   ( gpio_oe   ),
    .alt_a_out_i ( alt_a_out ),
    .alt_b_out_i ( alt_b_out ),
    .pad_in_i    ( pad_in    ),
    .pad_out_o   ( pad_out   ),
    .pad_oe_o    ( pad_oe    ),
    .gpio_in_o   ( gpio_in   ),
    .alt_in_o    ( alt_in    )
  );

  // two unrelated periods, ref_clk runs free of host_clk
  initial host_clk = 1'b0;
  always #20 host_clk = ~host_clk;

  initial ref_clk = 1'b0;
  always #(REF_PERIOD_NS / 2) ref_clk = ~ref_clk;

  //////////////////////////////////////////////////////////////////////
  // checking helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  // pad n uses nibble n of the two words, sel in [1:0], oe in [2]
  function automatic logic [63:0] route_pads(input logic [`PAD_DATA_W-1:0] w0,
                                             input logic [`PAD_DATA_W-1:0] w1);
    logic [3:0]               nib;
    logic [`PAD_NUM_PADS-1:0] o;
    logic [`PAD_NUM_PADS-1:0] e;
    logic [`PAD_NUM_PADS-1:0] gi;
    logic [`PAD_NUM_PADS-1:0] ai;
    o  = '0;
    e  = '0;
    gi = '0;
    ai = '0;
    for (int n = 0; n < `PAD_NUM_PADS; n++) begin
      nib = (n < 8) ? w0[4*n +: 4] : w1[4*(n-8) +: 4];
      case (nib[1:0])
        2'd0: begin
          o[n]  = gpio_out[n];
          e[n]  = gpio_oe[n];
          gi[n] = pad_in[n];
        end
        2'd1: begin
          o[n]  = alt_a_out[n];
          e[n]  = nib[2];
          ai[n] = pad_in[n];
        end
        2'd2: begin
          o[n]  = alt_b_out[n];
          e[n]  = nib[2];
          ai[n] = pad_in[n];
        end
        default: ;
      endcase
    end
    return {o, e, gi, ai};
  endfunction

  task automatic shuffle_pad_inputs();
    gpio_out  = $urandom;
    gpio_oe   = $urandom;
    alt_a_out = $urandom;
    alt_b_out = $urandom;
    pad_in    = $urandom;
  endtask

  //////////////////////////////////////////////////////////////////////
  // response monitor
  //////////////////////////////////////////////////////////////////////

  // rsp_valid is a full host cycle pulse, sampled mid cycle
  always @(negedge host_clk) begin
    if (rst_n && rsp_valid) begin
      check_responses();
    end
  end

  task automatic check_responses();
    exp_t  exp;
    string name;
    if (exp_q.size() == 0) begin
      $display("response seen with no request outstanding");
      $display("=== FAIL ===");
      $fatal(1);
    end
    exp  = exp_q.pop_front();
    name = name_q.pop_front();
    check_value({name, " rdata"}, exp.rdata, rsp_rdata);
    check_value({name, " error"}, exp.error, rsp_error);
    if (exp.pads) begin
      shuffle_pad_inputs();
      #2;
      check_value({name, " pads"}, route_pads(exp.w0, exp.w1),
                  {pad_out, pad_oe, gpio_in, alt_in});
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // entered on a falling edge, leaves req_valid high on the next one
  task automatic offer_req(input string name, input logic write,
                           input logic [`PAD_ADDR_W-1:0] addr,
                           input logic [`PAD_DATA_W-1:0] wdata);
    exp_t exp;
    while (req_full) begin
      saw_full  = 1'b1;
      req_valid = 1'b0;
      @(negedge host_clk);
    end
    req_valid = 1'b1;
    req_write = write;
    req_addr  = addr;
    req_wdata = wdata;
    exp.rdata = '0;
    exp.error = (addr >= `PAD_REG_COUNT);
    exp.pads  = write;
    if (!exp.error && write) begin
      model_words[addr] = wdata & RSVD_CLR;
    end else if (!exp.error) begin
      exp.rdata = model_words[addr];
    end
    exp.w0 = model_words[0];
    exp.w1 = model_words[1];
    @(posedge host_clk);
    exp_q.push_back(exp);
    name_q.push_back(name);
    @(negedge host_clk);
  endtask

  task automatic wait_drained();
    req_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge host_clk);
    end
    repeat (2) @(negedge host_clk);
  endtask

  initial begin
    #(NUM_OPS * 60 * REF_PERIOD_NS);
    $display("timeout with %0d responses still missing", exp_q.size());
    $display("=== FAIL ===");
    $fatal(1);
  end

  initial begin
    void'($urandom(32'h151));
    saw_full       = 1'b0;
    model_words[0] = 32'h3333_3333;
    model_words[1] = 32'h3333_3333;
    rst_n          = 1'b0;
    req_valid      = 1'b0;
    req_write      = 1'b0;
    req_addr       = '0;
    req_wdata      = '0;
    gpio_out       = '0;
    gpio_oe        = '0;
    alt_a_out      = '0;
    alt_b_out      = '0;
    pad_in         = '0;
    repeat (8) @(posedge host_clk);
    @(negedge host_clk);
    rst_n = 1'b1;

    // reset state, all pads off
    shuffle_pad_inputs();
    #2;
    check_value("reset full", 0, req_full);
    check_value("reset rsp_valid", 0, rsp_valid);
    check_value("reset pad_oe", 0, pad_oe);
    check_value("reset pad_out", 0, pad_out);
    @(negedge host_clk);
    offer_req("reset read 0", 1'b0, 0, '0);
    offer_req("reset read 1", 1'b0, 1, '0);
    wait_drained();

    for (int i = 0; i < P2_OPS; i++) begin
      offer_req("random access", $urandom_range(0, 1), $urandom_range(0, 1), $urandom);
      req_valid = 1'b0;
      repeat ($urandom_range(0, 3)) @(negedge host_clk);
    end
    wait_drained();

    for (int i = 0; i < P3_OPS; i++) begin
      offer_req("bad address", $urandom_range(0, 1), $urandom_range(2, 15), $urandom);
    end
    offer_req("readback 0", 1'b0, 0, '0);
    offer_req("readback 1", 1'b0, 1, '0);
    wait_drained();

    // back to back so the queue fills
    for (int b = 0; b < BURSTS; b++) begin
      for (int k = 0; k < BURST_LEN; k++) begin
        offer_req("burst", $urandom_range(0, 1), $urandom_range(0, 3), $urandom);
      end
      wait_drained();
    end
    check_value("burst fill", 1, saw_full);

    $display("=== PASS ===");
    $finish;
  end

endmodule
